//--- hud_params.svh
`ifndef HUD_PARAMS_SVH
`define HUD_PARAMS_SVH

// glyph sprite sizes in pixels
`define HUD_DIGIT_W 18
`define HUD_DIGIT_H 21
`define HUD_HI_W 38

// screen layout of the overlay row
`define HUD_ROW_Y 20
// first running-score digit
`define HUD_SCORE_X 100
`define HUD_HI_X 340
// first high-score digit
`define HUD_HSCORE_X 380
`define HUD_DIGIT_STEP 20

// sprite ROM bases
// digits 0..9 are stored back to back, one 18x21 sprite each
`define HUD_DIGIT_BASE 168215
`define HUD_HI_BASE 84217

// score timing and limits
// clock cycles per score tick
`define HUD_FRAME_DIV 10
`define HUD_BONUS 100
`define HUD_SCORE_MAX 99999

`endif

//--- hudPkg.sv
package hudPkg;

	// game phase as seen by the overlay
	typedef enum logic [1:0]
	{
		gsReady = 2'd0,
		gsPlay  = 2'd1,
		gsOver  = 2'd2
	} gameState_e;

	// glyph under the probed pixel
	// digits run most significant first
	typedef enum logic [2:0]
	{
		glOff    = 3'd0,
		glDigit1 = 3'd1,
		glDigit2 = 3'd2,
		glDigit3 = 3'd3,
		glDigit4 = 3'd4,
		glDigit5 = 3'd5,
		glHi     = 3'd6
	} glyphSel_e;

endpackage

//--- drawScore.sv
`include "hud_params.svh"

module drawScore
(
	input  logic                frame_Clk,
	input  logic                Reset,
	input  logic                restart,
	input  hudPkg::gameState_e  gameState,
	input  logic                dead,
	input  logic                bonus,
	input  logic [9:0]          probeX,
	input  logic [9:0]          probeY,
	output logic [16:0]         score,
	output hudPkg::glyphSel_e   scoreGlyph,
	output logic [3:0]          scoreDigit
);

	localparam int PreW = $clog2(`HUD_FRAME_DIV);

	logic [PreW-1:0] prescale;
	logic frameTick;
	logic counting;
	logic [16:0] scoreStep;
	logic [16:0] scoreSum;
	logic [3:0] digits [5];
	logic [2:0] slot;

	// free-running frame divider, wraps every HUD_FRAME_DIV cycles
	assign frameTick = (prescale == PreW'(`HUD_FRAME_DIV - 1));

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			prescale <= '0;
		else if (frameTick)
			prescale <= '0;
		else
			prescale <= prescale + 1'b1;
	end

	// bonus replaces the normal tick when both land together
	always_comb
	begin
		counting = (gameState == hudPkg::gsPlay) && !dead;
		if (counting && bonus)
			scoreStep = 17'(`HUD_BONUS);
		else if (counting && frameTick)
			scoreStep = 17'd1;
		else
			scoreStep = '0;
		scoreSum = score + scoreStep;
	end

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			score <= '0;
		else if (restart)
			score <= '0;
		else if (scoreSum > 17'(`HUD_SCORE_MAX))
			score <= '0;
		else
			score <= scoreSum;
	end

	// decimal split, digits[0] is the ten-thousands place
	always_comb
	begin
		digits[0] = 4'(score / 17'd10000);
		digits[1] = 4'((score / 17'd1000) % 17'd10);
		digits[2] = 4'((score / 17'd100) % 17'd10);
		digits[3] = 4'((score / 17'd10) % 17'd10);
		digits[4] = 4'(score % 17'd10);
	end

	// five digit boxes on the overlay row
	always_comb
	begin
		scoreGlyph = hudPkg::glOff;
		slot = '0;
		if ((probeY >= `HUD_ROW_Y) && (probeY < `HUD_ROW_Y + `HUD_DIGIT_H))
		begin
			for (int i = 0; i < 5; i++)
			begin
				if ((probeX >= `HUD_SCORE_X + i * `HUD_DIGIT_STEP) &&
					(probeX < `HUD_SCORE_X + i * `HUD_DIGIT_STEP + `HUD_DIGIT_W))
				begin
					scoreGlyph = hudPkg::glyphSel_e'(3'(i + 1));
					slot = 3'(i);
				end
			end
		end
		scoreDigit = digits[slot];
	end

	// wrap logic must keep the score inside five decimal digits
	scoreInRange: assert property (@(posedge frame_Clk) disable iff (Reset)
		score <= 17'(`HUD_SCORE_MAX));

endmodule

//--- drawHscore.sv
`include "hud_params.svh"

module drawHscore
(
	input  logic                frame_Clk,
	input  logic                Reset,
	input  hudPkg::gameState_e  gameState,
	input  logic [16:0]         score,
	input  logic [9:0]          probeX,
	input  logic [9:0]          probeY,
	output logic [16:0]         hiScore,
	output hudPkg::glyphSel_e   hiGlyph,
	output logic [3:0]          hiDigit
);

	logic loadHi;
	logic rowHit;
	logic [3:0] digits [5];
	logic [2:0] slot;

	// only a finished game can raise the record
	assign loadHi = (gameState == hudPkg::gsOver) && (score > hiScore);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
			hiScore <= '0;
		else if (loadHi)
			hiScore <= score;
	end

	always_comb
	begin
		digits[0] = 4'(hiScore / 17'd10000);
		digits[1] = 4'((hiScore / 17'd1000) % 17'd10);
		digits[2] = 4'((hiScore / 17'd100) % 17'd10);
		digits[3] = 4'((hiScore / 17'd10) % 17'd10);
		digits[4] = 4'(hiScore % 17'd10);
	end

	assign rowHit = (probeY >= `HUD_ROW_Y) && (probeY < `HUD_ROW_Y + `HUD_DIGIT_H);

	// "HI" label sits left of the digits, boxes do not overlap
	always_comb
	begin
		hiGlyph = hudPkg::glOff;
		slot = '0;
		if (rowHit)
		begin
			if ((probeX >= `HUD_HI_X) && (probeX < `HUD_HI_X + `HUD_HI_W))
				hiGlyph = hudPkg::glHi;
			for (int i = 0; i < 5; i++)
			begin
				if ((probeX >= `HUD_HSCORE_X + i * `HUD_DIGIT_STEP) &&
					(probeX < `HUD_HSCORE_X + i * `HUD_DIGIT_STEP + `HUD_DIGIT_W))
				begin
					hiGlyph = hudPkg::glyphSel_e'(3'(i + 1));
					slot = 3'(i);
				end
			end
		end
		// label hit leaves slot at zero, the digit is ignored downstream
		hiDigit = digits[slot];
	end

	// record only ever moves up between resets
	hiMonotonic: assert property (@(posedge frame_Clk) disable iff (Reset)
		hiScore >= $past(hiScore));

endmodule

//--- hudCombiner.sv
`include "hud_params.svh"

module hudCombiner
(
	input  logic                frame_Clk,
	input  logic                Reset,
	input  logic [9:0]          writeX,
	input  logic [9:0]          writeY,
	input  logic                lookupReq,
	input  hudPkg::glyphSel_e   scoreGlyph,
	input  logic [3:0]          scoreDigit,
	input  hudPkg::glyphSel_e   hiGlyph,
	input  logic [3:0]          hiDigit,
	output logic [9:0]          probeX,
	output logic [9:0]          probeY,
	output logic                lookupAck,
	output hudPkg::glyphSel_e   glyph,
	output logic [17:0]         address
);

	typedef enum logic [1:0]
	{
		csIdle = 2'd0,
		csEval = 2'd1,
		csAck  = 2'd2
	} combState_e;

	combState_e state;
	logic hiWins;
	hudPkg::glyphSel_e winGlyph;
	logic [3:0] winDigit;
	logic [2:0] digitSlot;
	logic [9:0] boxX;
	logic [9:0] colOff;
	logic [9:0] rowOff;
	logic [17:0] nextAddress;

	assign lookupAck = (state == csAck);

	// coordinates captured once per request
	always_ff @(posedge frame_Clk)
	begin
		if ((state == csIdle) && lookupReq)
		begin
			probeX <= writeX;
			probeY <= writeY;
		end
	end

	// high-score path wins whenever it reports a hit
	always_comb
	begin
		hiWins = (hiGlyph != hudPkg::glOff);
		winGlyph = hiWins ? hiGlyph : scoreGlyph;
		winDigit = hiWins ? hiDigit : scoreDigit;
		digitSlot = 3'(winGlyph) - 3'd1;
		rowOff = probeY - 10'(`HUD_ROW_Y);
		case (winGlyph)
			hudPkg::glOff:
				boxX = '0;
			hudPkg::glHi:
				boxX = 10'(`HUD_HI_X);
			default:
				boxX = (hiWins ? 10'(`HUD_HSCORE_X) : 10'(`HUD_SCORE_X)) +
					10'(digitSlot) * 10'(`HUD_DIGIT_STEP);
		endcase
		colOff = probeX - boxX;
		case (winGlyph)
			hudPkg::glOff:
				nextAddress = '0;
			hudPkg::glHi:
				nextAddress = 18'(`HUD_HI_BASE) + 18'(rowOff) * 18'(`HUD_HI_W) + 18'(colOff);
			default:
				nextAddress = 18'(`HUD_DIGIT_BASE) +
					18'(winDigit) * 18'(`HUD_DIGIT_W * `HUD_DIGIT_H) +
					18'(rowOff) * 18'(`HUD_DIGIT_W) + 18'(colOff);
		endcase
	end

	// four-phase sequencer, result loads one edge after the probe
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= csIdle;
			glyph <= hudPkg::glOff;
			address <= '0;
		end
		else
		begin
			case (state)
				csIdle:
					if (lookupReq)
						state <= csEval;
				csEval:
				begin
					glyph <= winGlyph;
					address <= nextAddress;
					state <= csAck;
				end
				csAck:
					if (!lookupReq)
						state <= csIdle;
				default:
					state <= csIdle;
			endcase
		end
	end

	// requester must still be holding req when ack comes up
	ackNeedsReq: assert property (@(posedge frame_Clk) disable iff (Reset)
		$rose(lookupAck) |-> $past(lookupReq));

	ackHoldsResult: assert property (@(posedge frame_Clk) disable iff (Reset)
		lookupAck && $past(lookupAck) |-> $stable(glyph) && $stable(address));

endmodule

//--- scoreHud.sv
module scoreHud
(
	input  logic                frame_Clk,
	input  logic                Reset,
	input  logic                restart,
	input  hudPkg::gameState_e  gameState,
	input  logic                dead,
	input  logic                bonus,
	input  logic                lookupReq,
	input  logic [9:0]          writeX,
	input  logic [9:0]          writeY,
	output logic                lookupAck,
	output hudPkg::glyphSel_e   glyph,
	output logic [17:0]         address,
	output logic [16:0]         score,
	output logic [16:0]         hiScore
);

	// latched lookup coordinates shared by both draw paths
	logic [9:0] probeX;
	logic [9:0] probeY;

	// per-path hit results
	hudPkg::glyphSel_e scoreGlyph;
	hudPkg::glyphSel_e hiGlyph;
	logic [3:0] scoreDigit;
	logic [3:0] hiDigit;

	drawScore i_drawScore
	(
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.restart    (restart),
		.gameState  (gameState),
		.dead       (dead),
		.bonus      (bonus),
		.probeX     (probeX),
		.probeY     (probeY),
		.score      (score),
		.scoreGlyph (scoreGlyph),
		.scoreDigit (scoreDigit)
	);

	drawHscore i_drawHscore
	(
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.gameState (gameState),
		.score     (score),
		.probeX    (probeX),
		.probeY    (probeY),
		.hiScore   (hiScore),
		.hiGlyph   (hiGlyph),
		.hiDigit   (hiDigit)
	);

	hudCombiner i_hudCombiner
	(
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.writeX     (writeX),
		.writeY     (writeY),
		.lookupReq  (lookupReq),
		.scoreGlyph (scoreGlyph),
		.scoreDigit (scoreDigit),
		.hiGlyph    (hiGlyph),
		.hiDigit    (hiDigit),
		.probeX     (probeX),
		.probeY     (probeY),
		.lookupAck  (lookupAck),
		.glyph      (glyph),
		.address    (address)
	);

endmodule

//--- scoreHud_tb.sv
`include "hud_params.svh"

module scoreHud_tb;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int AckTimeout = 20;

	// command codes in the first column of the stim file
	typedef enum int
	{
		opState   = 0,
		opDead    = 1,
		opBonus   = 2,
		opRestart = 3,
		opWait    = 4,
		opLook    = 5
	} stimOp_e;

	logic frame_Clk;
	logic Reset;
	logic restart;
	hudPkg::gameState_e gameState;
	logic dead;
	logic bonus;
	logic lookupReq;
	logic [9:0] writeX;
	logic [9:0] writeY;
	logic lookupAck;
	hudPkg::glyphSel_e glyph;
	logic [17:0] address;
	logic [16:0] score;
	logic [16:0] hiScore;

	scoreHud i_scoreHud
	(
		.frame_Clk (frame_Clk),
		.Reset     (Reset),
		.restart   (restart),
		.gameState (gameState),
		.dead      (dead),
		.bonus     (bonus),
		.lookupReq (lookupReq),
		.writeX    (writeX),
		.writeY    (writeY),
		.lookupAck (lookupAck),
		.glyph     (glyph),
		.address   (address),
		.score     (score),
		.hiScore   (hiScore)
	);

	initial
	begin
		frame_Clk = 1'b0;
		forever
			#5 frame_Clk = ~frame_Clk;
	end

	task automatic checkValue(input string name, input int got, input int expected);
		if (got != expected)
		begin
			$display("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, expected);
			$display("** FAIL **");
			$fatal(1);
		end
	endtask

	task automatic stopRun(input string why);
		$display("%s at %0t", why, $time);
		$display("** FAIL **");
		$fatal(1);
	endtask

	// decimal digit of a five digit value, place 0 is the ten-thousands
	function automatic int decimalDigit(input int value, input int place);
		int divisor;
		divisor = 1;
		for (int i = 0; i < 4 - place; i++)
			divisor = divisor * 10;
		return (value / divisor) % 10;
	endfunction

	// sprite address from the layout rules, digits taken from the score ports
	function automatic int expectAddress(input int x, input int y, input int g);
		int boxX;
		int digit;
		if (g == 0)
			return 0;
		if (g == 6)
			return `HUD_HI_BASE + (y - `HUD_ROW_Y) * `HUD_HI_W + (x - `HUD_HI_X);
		if (x >= `HUD_HI_X)
		begin
			boxX = `HUD_HSCORE_X + (g - 1) * `HUD_DIGIT_STEP;
			digit = decimalDigit(int'(hiScore), g - 1);
		end
		else
		begin
			boxX = `HUD_SCORE_X + (g - 1) * `HUD_DIGIT_STEP;
			digit = decimalDigit(int'(score), g - 1);
		end
		return `HUD_DIGIT_BASE + digit * `HUD_DIGIT_W * `HUD_DIGIT_H +
			(y - `HUD_ROW_Y) * `HUD_DIGIT_W + (x - boxX);
	endfunction

	function automatic bit isCounting();
		return (gameState == hudPkg::gsPlay) && !dead;
	endfunction

	// full four-phase lookup, req held a few extra cycles
	task automatic doLookup(input int x, input int y, input int expGlyph);
		int cnt;
		int expAddr;
		int holdGlyph;
		int holdAddr;
		if (lookupAck)
			stopRun("lookupAck still high before a new request");
		@(posedge frame_Clk);
		writeX <= 10'(x);
		writeY <= 10'(y);
		lookupReq <= 1'b1;
		cnt = 0;
		@(negedge frame_Clk);
		while (!lookupAck)
		begin
			if (cnt >= AckTimeout)
				stopRun("lookupAck never rose");
			cnt++;
			@(negedge frame_Clk);
		end
		expAddr = expectAddress(x, y, expGlyph);
		checkValue("glyph", int'(glyph), expGlyph);
		checkValue("address", int'(address), expAddr);
		holdGlyph = int'(glyph);
		holdAddr = int'(address);
		repeat (3)
		begin
			@(negedge frame_Clk);
			checkValue("lookupAck", int'(lookupAck), 1);
			checkValue("glyph", int'(glyph), holdGlyph);
			checkValue("address", int'(address), holdAddr);
		end
		@(posedge frame_Clk);
		lookupReq <= 1'b0;
		cnt = 0;
		@(negedge frame_Clk);
		while (lookupAck)
		begin
			if (cnt >= AckTimeout)
				stopRun("lookupAck never fell");
			cnt++;
			@(negedge frame_Clk);
		end
	endtask

	initial
	begin
		int fd;
		int n;
		int op;
		int a;
		int b;
		int c;
		int prevScore;
		int prevHi;
		string line;
		Reset = 1'b1;
		restart = 1'b0;
		gameState = hudPkg::gsReady;
		dead = 1'b0;
		bonus = 1'b0;
		lookupReq = 1'b0;
		writeX = '0;
		writeY = '0;
		repeat (4)
			@(posedge frame_Clk);
		Reset <= 1'b0;
		@(negedge frame_Clk);
		checkValue("lookupAck", int'(lookupAck), 0);
		checkValue("glyph", int'(glyph), 0);
		checkValue("address", int'(address), 0);
		checkValue("score", int'(score), 0);
		checkValue("hiScore", int'(hiScore), 0);

		fd = $fopen("scoreHud_stim.txt", "r");
		if (fd == 0)
			stopRun("cannot open scoreHud_stim.txt");
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			a = 0;
			b = 0;
			c = 0;
			n = 0;
			if ((line.len() > 0) && (line[0] != "#"))
				n = $sscanf(line, "%d %d %d %d", op, a, b, c);
			if (n >= 2)
			begin
				prevScore = int'(score);
				prevHi = int'(hiScore);
				case (stimOp_e'(op))
					opState, opDead, opBonus, opRestart:
					begin
						@(posedge frame_Clk);
						if (op == opState)
							gameState <= hudPkg::gameState_e'(a[1:0]);
						else if (op == opDead)
							dead <= a[0];
						else if (op == opBonus)
							bonus <= 1'b1;
						else
							restart <= 1'b1;
						// second edge samples the new input
						@(posedge frame_Clk);
						bonus <= 1'b0;
						restart <= 1'b0;
						@(negedge frame_Clk);
						if (op == opBonus)
						begin
							if (isCounting())
							begin
								if (int'(score) < prevScore + `HUD_BONUS)
									stopRun("bonus did not raise the score");
							end
							// a frozen or dead game ignores the bonus
							else
								checkValue("score", int'(score), prevScore);
						end
						else if (op == opRestart)
							checkValue("score", int'(score), 0);
						if ((op == opState) && (gameState == hudPkg::gsOver))
							checkValue("hiScore", int'(hiScore),
								(prevHi > int'(score)) ? prevHi : int'(score));
					end
					opWait:
						repeat (a)
						begin
							@(negedge frame_Clk);
							if (isCounting())
							begin
								if (int'(score) < prevScore)
									stopRun("score decreased during play");
							end
							else
								checkValue("score", int'(score), prevScore);
							prevScore = int'(score);
						end
					opLook:
						doLookup(a, b, c);
					default:
						stopRun("unknown command in stim file");
				endcase
			end
		end
		$fclose(fd);
		$display("** PASS **");
		$finish;
	end

endmodule

//--- scoreHud_stim.txt
# columns: op arg1 arg2 arg3
# op 0 state, 1 dead, 2 bonus, 3 restart, 4 wait cycles, 5 look x y glyph
# idle screen, score is zero
5 100 20 1
5 117 40 1
5 50 50 0
5 340 25 6
# play and count
0 1 0 0
4 55 0 0
2 0 0 0
4 30 0 0
2 0 0 0
4 47 0 0
# freeze and read the running score
0 0 0 0
4 20 0 0
5 100 20 1
5 125 30 2
5 140 20 3
5 165 35 4
5 187 40 5
5 118 20 0
5 100 41 0
5 100 19 0
# dead player does not score
0 1 0 0
1 1 0 0
4 30 0 0
2 0 0 0
4 10 0 0
1 0 0 0
4 25 0 0
# game over takes the record
0 2 0 0
4 5 0 0
5 345 25 6
5 377 40 6
5 380 20 1
5 405 30 2
5 420 21 3
5 445 33 4
5 465 40 5
5 398 25 0
5 300 25 0
# restart and a shorter game
3 0 0 0
0 1 0 0
4 40 0 0
0 2 0 0
4 5 0 0
5 470 30 5
0 0 0 0
5 100 20 1
5 181 22 5

//--- scoreHud.f
+incdir+.
hudPkg.sv
drawScore.sv
drawHscore.sv
hudCombiner.sv
scoreHud.sv
scoreHud_tb.sv

//--- Makefile
# Verilator build for the score overlay testbench

TOP = scoreHud_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --assert --timescale 1ns/100ps \
		-f scoreHud.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)

run: compile
	./obj_dir/$(TOP) | tee sim.log
	@if grep -q -F '** FAIL **' sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q -F '** PASS **' sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
